//--- bench/resdmac_testdata.txt
// Each record is three hex words: type, register word or memory byte address, value
// Types: 1 reg write, 2 reg read, 3 SCSI to memory, 4 memory to SCSI, 5 wait(1), check int_o
5 0 0      2 7 4
1 1 3      1 2 3      1 3 1000
2 1 3      2 2 3      2 3 1000
3 1000 11223344      3 1004 55667788      3 1008 99aabbcc
1 4 0      5 1 1
2 7 5      2 3 100c
1 6 0      5 0 0      2 7 4
1 1 2      1 2 6      1 3 2000
4 2000 deadbeef      4 2004 0badf00d
1 4 0      5 1 0
2 7 5      2 3 2008
1 6 0      2 7 4
0 0 0

//--- files.f
design/cpuBusPkg.sv
design/scsiDmaPkg.sv
design/dmacRegisters.sv
design/dmaFifo.sv
design/scsiPort.sv
design/cpuBusMaster.sv
design/dmaControl.sv
design/resdmac.sv
bench/resdmacTb.sv

//--- Bender.yml
package:
  name: resdmac

sources:
  - design/cpuBusPkg.sv
  - design/scsiDmaPkg.sv
  - design/dmacRegisters.sv
  - design/dmaFifo.sv
  - design/scsiPort.sv
  - design/cpuBusMaster.sv
  - design/dmaControl.sv
  - design/resdmac.sv
  - target: test
    files:
      - bench/resdmacTb.sv

//--- bench/resdmacTb.sv
`timescale 1ns/1ps

module resdmacTb;
    import cpuBusPkg::*;
    import scsiDmaPkg::*;

    localparam int maxRecords = 64;

    logic       sclk = 1'b0;
    logic       rst;
    regAccess_t regAccess;
    longWord_t  regRdata;
    logic       irq, br, bg, own, dsack, dreq, dack, ior, iow;
    memCycle_t  memCycle;
    longWord_t  memRdata;
    scsiByte_t  pdIn, pdOut;

    logic [31:0] testData [3*maxRecords];   // Records of type, address, value
    longWord_t   memory [memAddr_t];        // Sparse memory model
    scsiByte_t   srcBytes[$];               // Bytes the SCSI device still has to supply
    scsiByte_t   expBytes[$];               // Bytes the SCSI device should still receive
    memAddr_t    expAddr[$];
    longWord_t   expWord[$];
    int          writeCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;
    integer      seed = 32'he5777303;
    int          grantWait = 0;
    int          ackWait = 0;
    logic        strobeSeen = 1'b0;
    logic        reqWaiting = 1'b0;         // Request was up with no grant driven

    resdmac #(.fifoDepth(4), .ioPulseCycles(3)) dut0 (
        .sclk_i(sclk), .rst_i(rst), .regAccess_i(regAccess), .regRdata_o(regRdata),
        .int_o(irq), .br_o(br), .bg_i(bg), .own_o(own), .memCycle_o(memCycle),
        .dsack_i(dsack), .memRdata_i(memRdata), .dreq_i(dreq), .dack_o(dack),
        .ior_o(ior), .iow_o(iow), .pd_i(pdIn), .pd_o(pdOut)
    );

    always #5 sclk = ~sclk;

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    always @(posedge sclk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            stopRun($sformatf("Timeout: run still busy after %0d cycles", cycleCount));
        end
    end

    // Arbiter, memory and SCSI device models
    always @(negedge sclk) begin
        assert (!reqWaiting || br) else stopRun("Bus request dropped before the grant");
        assert (!(br && own)) else stopRun("Bus request still raised while owning the bus");
        if (!br) begin
            bg = 1'b0;
            grantWait = $random(seed) & 3;      // Grant delay of 0 to 3 cycles
        end else if (grantWait == 0) begin
            bg = 1'b1;
        end else begin
            grantWait--;
        end
        reqWaiting = br && !bg;
        if (!memCycle.as) begin
            dsack = 1'b0;
            ackWait = $random(seed) & 3;
        end else if (!dsack) begin
            if (ackWait == 0) begin
                dsack = 1'b1;
                if (memCycle.write) begin
                    memory[memCycle.addr] = memCycle.wdata;
                    writeCount++;
                end else begin
                    memRdata = memory.exists(memCycle.addr) ? memory[memCycle.addr] : '0;
                end
            end else begin
                ackWait--;
            end
        end
        // A new strobe may only follow a raised device request
        if ((ior || iow) && !strobeSeen) begin
            assert (dreq) else stopRun("SCSI strobe started while DMA request was low");
        end
        dreq = ($random(seed) & 3) != 0;        // Gaps in the device request
        if (ior || iow) begin
            assert (dack) else stopRun("DMA acknowledge low during an I/O strobe");
        end
        if (ior && !strobeSeen) begin
            assert (srcBytes.size() != 0) else stopRun("SCSI read strobe with no byte left");
            pdIn = srcBytes.pop_front();
        end
        if (iow && !strobeSeen) begin
            assert (expBytes.size() != 0) else stopRun("SCSI write strobe with no byte due");
            assert (pdOut == expBytes[0]) else
                stopRun($sformatf("mismatch at %0t: pd_o %h, expected %h",
                                  $time, pdOut, expBytes[0]));
            void'(expBytes.pop_front());
        end
        strobeSeen = ior || iow;
        assert (own || !memCycle.as) else stopRun("Address strobe raised without bus ownership");
    end

    task automatic writeReg(input regAddr_t addr, input longWord_t data);
        @(negedge sclk);
        regAccess = {1'b1, 1'b1, addr, data};
        @(negedge sclk);
        regAccess = '0;
    endtask

    task automatic readReg(input regAddr_t addr, output longWord_t data);
        @(negedge sclk);
        regAccess = {1'b1, 1'b0, addr, 32'h0};
        @(negedge sclk);
        regAccess = '0;
        data = regRdata;   // Registered one cycle after the select
    endtask

    task automatic waitDone();
        longWord_t istr;
        do begin
            readReg(REG_ISTR, istr);
        end while (!istr[0]);
    endtask

    // Memory contents and byte queues after a finished transfer
    task automatic checkTransfer();
        assert (writeCount == expAddr.size()) else
            stopRun($sformatf("mismatch at %0t: %0d memory writes, expected %0d",
                              $time, writeCount, expAddr.size()));
        foreach (expAddr[i]) begin
            assert (memory.exists(expAddr[i]) && memory[expAddr[i]] == expWord[i]) else
                stopRun($sformatf("mismatch at %0t: memory at %h is %h, expected %h",
                                  $time, expAddr[i], memory[expAddr[i]], expWord[i]));
        end
        assert (srcBytes.size() == 0 && expBytes.size() == 0) else
            stopRun("Transfer ended before all SCSI bytes were moved");
        expAddr.delete();
        expWord.delete();
        writeCount = 0;
    endtask

    initial begin
        int          nRec;
        int          nWords;
        logic [31:0] kind, addr, value;
        longWord_t   rdata;
        rst = 1'b1;
        regAccess = '0;
        bg = 1'b0;
        dsack = 1'b0;
        memRdata = '0;
        dreq = 1'b0;
        pdIn = '0;
        $readmemh("bench/resdmac_testdata.txt", testData);
        nRec = 0;
        nWords = 0;
        while (nRec < maxRecords && !$isunknown(testData[3*nRec]) && testData[3*nRec] != 0) begin
            if (testData[3*nRec] == 3 || testData[3*nRec] == 4) begin
                nWords++;
            end
            nRec++;
        end
        assert (nRec > 0) else stopRun("Test data file is empty or missing");
        cycleLimit = 40 * 4 * nWords + 10 * nRec;   // 40 per byte, 10 per record
        repeat (2) @(negedge sclk);
        rst = 1'b0;
        for (int i = 0; i < nRec; i++) begin
            kind = testData[3*i];
            addr = testData[3*i+1];
            value = testData[3*i+2];
            case (kind)
                1: writeReg(regAddr_t'(addr), value);
                2: begin
                    readReg(regAddr_t'(addr), rdata);
                    assert (rdata == value) else
                        stopRun($sformatf("mismatch at %0t: register %0d read %h, expected %h",
                                          $time, addr, rdata, value));
                end
                3: begin
                    for (int b = 3; b >= 0; b--) begin
                        srcBytes.push_back(value[8*b +: 8]);   // Big-endian with the MSB first
                    end
                    expAddr.push_back(addr);
                    expWord.push_back(value);
                end
                4: begin
                    memory[addr] = value;
                    for (int b = 3; b >= 0; b--) begin
                        expBytes.push_back(value[8*b +: 8]);
                    end
                end
                5: begin
                    if (addr[0]) begin
                        waitDone();
                        checkTransfer();
                    end
                    assert (irq == value[0]) else
                        stopRun($sformatf("mismatch at %0t: int_o %b, expected %b",
                                          $time, irq, value[0]));
                end
                default: stopRun($sformatf("Unknown record type %0d in test data", kind));
            endcase
        end
        $display("Everything OK");
        $finish;
    end

endmodule

//--- design/resdmac.sv
`timescale 1ns/1ps

module resdmac #(
    parameter int fifoDepth     = 4,
    parameter int ioPulseCycles = 3
) (
    input  logic                  sclk_i,
    input  logic                  rst_i,
    input  cpuBusPkg::regAccess_t regAccess_i,
    output cpuBusPkg::longWord_t  regRdata_o,
    output logic                  int_o,
    output logic                  br_o,
    input  logic                  bg_i,
    output logic                  own_o,
    output cpuBusPkg::memCycle_t  memCycle_o,
    input  logic                  dsack_i,
    input  cpuBusPkg::longWord_t  memRdata_i,
    input  logic                  dreq_i,
    output logic                  dack_o,
    output logic                  ior_o,
    output logic                  iow_o,
    input  scsiDmaPkg::scsiByte_t pd_i,
    output scsiDmaPkg::scsiByte_t pd_o
);
    import cpuBusPkg::*;
    import scsiDmaPkg::*;

    dmaCtrl_t   ctrl;
    xferCount_t count;
    memAddr_t   acr, curAddr;
    longWord_t  fifoWord, busRdata;
    scsiByte_t  fifoByte, rdByte;
    logic startDma, xferDone, acrUpdateEn;
    logic pushByte, popByte, pushWord, popWord;
    logic wordReady, byteAvail, fifoEmpty, fifoFull;
    logic ioStart, ioWrite, ioDone;
    logic busRequest, busRelease, granted, cycleStart, cycleWrite, loadAddr, cycleDone;

    dmacRegisters u_registers (
        .sclk_i, .rst_i, .regAccess_i,
        .status_i      ({fifoEmpty, fifoFull, 1'b0}),
        .xferDone_i    (xferDone),
        .acrUpdate_i   (curAddr),
        .acrUpdateEn_i (acrUpdateEn),
        .regRdata_o, .ctrl_o (ctrl), .count_o (count), .acr_o (acr),
        .startDma_o    (startDma),
        .int_o
    );

    dmaFifo #(.fifoDepth(fifoDepth)) u_fifo (
        .sclk_i, .rst_i,
        .pushByte_i  (pushByte), .byteIn_i (rdByte), .popByte_i (popByte),
        .pushWord_i  (pushWord), .wordIn_i (busRdata), .popWord_i (popWord),
        .byteOut_o   (fifoByte), .wordOut_o (fifoWord),
        .wordReady_o (wordReady), .byteAvail_o (byteAvail),
        .fifoEmpty_o (fifoEmpty), .fifoFull_o (fifoFull)
    );

    scsiPort #(.ioPulseCycles(ioPulseCycles)) u_scsiPort (
        .sclk_i, .rst_i,
        .ioStart_i (ioStart), .ioWrite_i (ioWrite), .wrByte_i (fifoByte),
        .pd_i, .pd_o, .dack_o, .ior_o, .iow_o,
        .rdByte_o  (rdByte), .ioDone_o (ioDone)
    );

    cpuBusMaster u_busMaster (
        .sclk_i, .rst_i,
        .busRequest_i (busRequest), .busRelease_i (busRelease), .bg_i,
        .cycleStart_i (cycleStart), .cycleWrite_i (cycleWrite), .wdata_i (fifoWord),
        .loadAddr_i   (loadAddr), .startAddr_i (acr),
        .dsack_i, .memRdata_i,
        .br_o, .own_o, .granted_o (granted), .memCycle_o,
        .rdata_o      (busRdata), .curAddr_o (curAddr), .cycleDone_o (cycleDone)
    );

    dmaControl u_control (
        .sclk_i, .rst_i,
        .ctrl_i        (ctrl), .count_i (count), .startDma_i (startDma), .dreq_i,
        .fifoFull_i    (fifoFull), .wordReady_i (wordReady), .byteAvail_i (byteAvail),
        .ioDone_i      (ioDone), .granted_i (granted), .cycleDone_i (cycleDone),
        .pushByte_o    (pushByte), .popByte_o (popByte),
        .pushWord_o    (pushWord), .popWord_o (popWord),
        .ioStart_o     (ioStart), .ioWrite_o (ioWrite),
        .busRequest_o  (busRequest), .busRelease_o (busRelease),
        .cycleStart_o  (cycleStart), .cycleWrite_o (cycleWrite),
        .loadAddr_o    (loadAddr), .xferDone_o (xferDone), .acrUpdateEn_o (acrUpdateEn)
    );

endmodule

//--- design/dmaControl.sv
`timescale 1ns/1ps

module dmaControl (
    input  logic                   sclk_i,
    input  logic                   rst_i,
    input  scsiDmaPkg::dmaCtrl_t   ctrl_i,
    input  scsiDmaPkg::xferCount_t count_i,
    input  logic                   startDma_i,
    input  logic                   dreq_i,
    input  logic                   fifoFull_i,
    input  logic                   wordReady_i,
    input  logic                   byteAvail_i,
    input  logic                   ioDone_i,
    input  logic                   granted_i,
    input  logic                   cycleDone_i,
    output logic                   pushByte_o,
    output logic                   popByte_o,
    output logic                   pushWord_o,
    output logic                   popWord_o,
    output logic                   ioStart_o,
    output logic                   ioWrite_o,
    output logic                   busRequest_o,
    output logic                   busRelease_o,
    output logic                   cycleStart_o,
    output logic                   cycleWrite_o,
    output logic                   loadAddr_o,
    output logic                   xferDone_o,
    output logic                   acrUpdateEn_o
);
    import scsiDmaPkg::*;

    dmaState_e  state;
    xferCount_t memLeft;     // Memory cycles still to run
    xferCount_t scsiLeft;    // Longwords the SCSI side still has to move
    logic [1:0] byteIdx;
    logic       ioBusy;
    logic       m2s;
    logic       active;
    logic       byteGo;
    logic       memGo;

    assign m2s    = ctrl_i.dir;
    assign active = (state == stScsiByte) || (state == stMemCycle);

    // Byte side runs alongside the memory cycles
    assign byteGo = active && !ioBusy && scsiLeft != '0 && dreq_i &&
                    (m2s ? byteAvail_i : !fifoFull_i);
    assign memGo  = (state == stScsiByte) && memLeft != '0 &&
                    (m2s ? !fifoFull_i : wordReady_i);

    assign ioStart_o     = byteGo;
    assign ioWrite_o     = m2s;
    assign pushByte_o    = ioDone_i && !m2s;
    assign popByte_o     = ioDone_i && m2s;
    assign cycleStart_o  = memGo;
    assign cycleWrite_o  = !m2s;
    assign popWord_o     = memGo && !m2s;          // Word goes out with the cycle start
    assign acrUpdateEn_o = (state == stMemCycle) && cycleDone_i;
    assign pushWord_o    = acrUpdateEn_o && m2s;
    assign busRequest_o  = state == stArbitrate;
    assign busRelease_o  = state == stDone;
    assign xferDone_o    = state == stDone;
    assign loadAddr_o    = (state == stIdle) && startDma_i && ctrl_i.ena;

    always_ff @(posedge sclk_i) begin
        if (rst_i) begin
            state    <= stIdle;
            memLeft  <= '0;
            scsiLeft <= '0;
            byteIdx  <= 2'd0;
            ioBusy   <= 1'b0;
        end else begin
            if (byteGo) begin
                ioBusy <= 1'b1;
            end else if (ioDone_i) begin
                ioBusy <= 1'b0;
            end
            if (ioDone_i) begin
                byteIdx <= byteIdx + 2'd1;
                if (byteIdx == 2'd3) scsiLeft <= scsiLeft - 1'b1;
            end
            case (state)
                stIdle: begin
                    if (loadAddr_o) begin
                        memLeft  <= count_i;
                        scsiLeft <= count_i;
                        byteIdx  <= 2'd0;
                        state    <= stArbitrate;
                    end
                end
                stArbitrate: if (granted_i) state <= stScsiByte;
                stScsiByte: begin
                    if (memGo) begin
                        state <= stMemCycle;
                    end else if (memLeft == '0 && scsiLeft == '0) begin
                        state <= stDone;
                    end
                end
                stMemCycle: begin
                    if (cycleDone_i) begin
                        memLeft <= memLeft - 1'b1;
                        state   <= stScsiByte;
                    end
                end
                stDone:  state <= stIdle;
                default: state <= stIdle;
            endcase
        end
    end

endmodule

//--- design/cpuBusMaster.sv
`timescale 1ns/1ps

module cpuBusMaster (
    input  logic                 sclk_i,
    input  logic                 rst_i,
    input  logic                 busRequest_i,
    input  logic                 busRelease_i,
    input  logic                 bg_i,
    input  logic                 cycleStart_i,
    input  logic                 cycleWrite_i,
    input  cpuBusPkg::longWord_t wdata_i,
    input  logic                 loadAddr_i,
    input  cpuBusPkg::memAddr_t  startAddr_i,
    input  logic                 dsack_i,
    input  cpuBusPkg::longWord_t memRdata_i,
    output logic                 br_o,
    output logic                 own_o,
    output logic                 granted_o,
    output cpuBusPkg::memCycle_t memCycle_o,
    output cpuBusPkg::longWord_t rdata_o,
    output cpuBusPkg::memAddr_t  curAddr_o,
    output logic                 cycleDone_o
);
    import cpuBusPkg::*;

    logic      asReg;
    logic      writeReg;
    longWord_t wdataReg;
    logic      cycleEnd;

    assign cycleEnd   = asReg && dsack_i;
    assign memCycle_o = '{as: asReg, write: writeReg, addr: curAddr_o, wdata: wdataReg};

    always_ff @(posedge sclk_i) begin
        if (rst_i) begin
            br_o        <= 1'b0;
            own_o       <= 1'b0;
            granted_o   <= 1'b0;
            asReg       <= 1'b0;
            cycleDone_o <= 1'b0;
        end else begin
            granted_o   <= 1'b0;
            cycleDone_o <= 1'b0;
            if (busRelease_i) begin
                own_o <= 1'b0;
            end else if (br_o && bg_i) begin   // Grant seen, take ownership
                br_o      <= 1'b0;
                own_o     <= 1'b1;
                granted_o <= 1'b1;
            end else if (busRequest_i && !own_o) begin
                br_o <= 1'b1;
            end
            if (cycleStart_i) begin
                asReg <= 1'b1;
            end else if (cycleEnd) begin       // Late dsack just holds the cycle
                asReg       <= 1'b0;
                cycleDone_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge sclk_i) begin
        if (loadAddr_i) begin
            curAddr_o <= startAddr_i;
        end else if (cycleEnd) begin
            curAddr_o <= curAddr_o + memAddr_t'(4);
        end
        if (cycleStart_i) begin
            writeReg <= cycleWrite_i;
            wdataReg <= wdata_i;
        end
        if (cycleEnd) rdata_o <= memRdata_i;
    end

endmodule

//--- design/scsiPort.sv
`timescale 1ns/1ps

module scsiPort #(
    parameter int ioPulseCycles = 3
) (
    input  logic                  sclk_i,
    input  logic                  rst_i,
    input  logic                  ioStart_i,
    input  logic                  ioWrite_i,
    input  scsiDmaPkg::scsiByte_t wrByte_i,
    input  scsiDmaPkg::scsiByte_t pd_i,
    output scsiDmaPkg::scsiByte_t pd_o,
    output logic                  dack_o,
    output logic                  ior_o,
    output logic                  iow_o,
    output scsiDmaPkg::scsiByte_t rdByte_o,
    output logic                  ioDone_o
);
    localparam int cntW = $clog2(ioPulseCycles + 1);

    logic [cntW-1:0] pulseCnt;   // Strobe cycles left

    always_ff @(posedge sclk_i) begin
        if (rst_i) begin
            pulseCnt <= '0;
            dack_o   <= 1'b0;
            ior_o    <= 1'b0;
            iow_o    <= 1'b0;
            ioDone_o <= 1'b0;
        end else begin
            ioDone_o <= 1'b0;
            if (ioStart_i) begin
                pulseCnt <= cntW'(ioPulseCycles);
                dack_o   <= 1'b1;
                ior_o    <= !ioWrite_i;
                iow_o    <= ioWrite_i;
            end else if (pulseCnt != '0) begin
                pulseCnt <= pulseCnt - 1'b1;
                if (pulseCnt == cntW'(1)) begin   // Last strobe cycle
                    dack_o   <= 1'b0;
                    ior_o    <= 1'b0;
                    iow_o    <= 1'b0;
                    ioDone_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge sclk_i) begin
        if (ioStart_i) pd_o <= wrByte_i;                     // Held for the whole pulse
        if (ior_o && pulseCnt == cntW'(1)) rdByte_o <= pd_i;
    end

endmodule

//--- design/dmaFifo.sv
`timescale 1ns/1ps

module dmaFifo #(
    parameter int fifoDepth = 4
) (
    input  logic                  sclk_i,
    input  logic                  rst_i,
    input  logic                  pushByte_i,
    input  scsiDmaPkg::scsiByte_t byteIn_i,
    input  logic                  popByte_i,
    input  logic                  pushWord_i,
    input  cpuBusPkg::longWord_t  wordIn_i,
    input  logic                  popWord_i,
    output scsiDmaPkg::scsiByte_t byteOut_o,
    output cpuBusPkg::longWord_t  wordOut_o,
    output logic                  wordReady_o,
    output logic                  byteAvail_o,
    output logic                  fifoEmpty_o,
    output logic                  fifoFull_o
);
    import cpuBusPkg::*;

    localparam int ptrW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
    localparam int cntW = $clog2(fifoDepth + 1);

    longWord_t       mem [fifoDepth];
    logic [ptrW-1:0] wrPtr, rdPtr;
    logic [cntW-1:0] count;
    logic [1:0]      inOff, outOff;   // Byte lane, 0 is bits 31:24
    logic            wordIn, wordOut;

    // An entry counts only once all four bytes are in
    assign wordIn  = pushWord_i || (pushByte_i && inOff == 2'd3);
    assign wordOut = popWord_i || (popByte_i && outOff == 2'd3);

    assign wordOut_o   = mem[rdPtr];
    assign byteOut_o   = mem[rdPtr][8*(3-outOff) +: 8];
    assign wordReady_o = count != '0;
    assign byteAvail_o = wordReady_o;                  // Bytes drain from whole words only
    assign fifoEmpty_o = (count == '0) && (inOff == 2'd0);
    assign fifoFull_o  = count == cntW'(fifoDepth);

    always_ff @(posedge sclk_i) begin
        if (pushWord_i) begin
            mem[wrPtr] <= wordIn_i;
        end else if (pushByte_i) begin
            mem[wrPtr][8*(3-inOff) +: 8] <= byteIn_i;
        end
    end

    always_ff @(posedge sclk_i) begin
        if (rst_i) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            count  <= '0;
            inOff  <= 2'd0;
            outOff <= 2'd0;
        end else begin
            if (pushByte_i) inOff <= inOff + 2'd1;
            if (popByte_i) outOff <= outOff + 2'd1;
            if (wordIn) wrPtr <= (wrPtr == ptrW'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            if (wordOut) rdPtr <= (rdPtr == ptrW'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            if (wordIn && !wordOut) begin
                count <= count + 1'b1;
            end else if (wordOut && !wordIn) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- design/dmacRegisters.sv
`timescale 1ns/1ps

module dmacRegisters (
    input  logic                    sclk_i,
    input  logic                    rst_i,
    input  cpuBusPkg::regAccess_t   regAccess_i,
    input  scsiDmaPkg::dmaStatus_t  status_i,      // intPending field is not used
    input  logic                    xferDone_i,
    input  cpuBusPkg::memAddr_t     acrUpdate_i,
    input  logic                    acrUpdateEn_i,
    output cpuBusPkg::longWord_t    regRdata_o,
    output scsiDmaPkg::dmaCtrl_t    ctrl_o,
    output scsiDmaPkg::xferCount_t  count_o,
    output cpuBusPkg::memAddr_t     acr_o,
    output logic                    startDma_o,
    output logic                    int_o
);
    import cpuBusPkg::*;
    import scsiDmaPkg::*;

    logic       wrEn;
    logic       intPending;
    dmaStatus_t istr;

    assign wrEn  = regAccess_i.sel && regAccess_i.write;
    assign istr  = '{fifoEmpty: status_i.fifoEmpty, fifoFull: status_i.fifoFull,
                     intPending: intPending};
    assign int_o = intPending && ctrl_o.intEna;

    always_ff @(posedge sclk_i) begin
        if (rst_i) begin
            count_o    <= '0;
            ctrl_o     <= '0;
            acr_o      <= '0;
            intPending <= 1'b0;
            startDma_o <= 1'b0;
        end else begin
            startDma_o <= wrEn && (regAccess_i.addr == REG_ST_DMA);
            if (wrEn && regAccess_i.addr == REG_WTC) begin
                count_o <= regAccess_i.wdata[$bits(xferCount_t)-1:0];
            end
            if (wrEn && regAccess_i.addr == REG_CNTR) begin
                ctrl_o <= dmaCtrl_t'(regAccess_i.wdata[$bits(dmaCtrl_t)-1:0]);
            end
            // The running address overrides a CPU write
            if (acrUpdateEn_i) begin
                acr_o <= acrUpdate_i;
            end else if (wrEn && regAccess_i.addr == REG_ACR) begin
                acr_o <= regAccess_i.wdata;
            end
            if (xferDone_i) begin
                intPending <= 1'b1;
            end else if (wrEn && regAccess_i.addr == REG_CINT) begin
                intPending <= 1'b0;
            end
        end
    end

    // Registered readback, valid the cycle after the select
    always_ff @(posedge sclk_i) begin
        if (regAccess_i.sel && !regAccess_i.write) begin
            case (regAccess_i.addr)
                REG_WTC:  regRdata_o <= longWord_t'(count_o);
                REG_CNTR: regRdata_o <= longWord_t'(ctrl_o);
                REG_ACR:  regRdata_o <= acr_o;
                REG_ISTR: regRdata_o <= longWord_t'(istr);
                default:  regRdata_o <= '0;
            endcase
        end
    end

endmodule

//--- design/scsiDmaPkg.sv
package scsiDmaPkg;

    typedef logic [7:0]  scsiByte_t;   // Peripheral port data
    typedef logic [15:0] xferCount_t;  // Transfer length in longwords

    // CNTR bits 2:0
    typedef struct packed {
        logic dir;      // 1 = memory to SCSI
        logic ena;
        logic intEna;
    } dmaCtrl_t;

    // ISTR bits 2:0
    typedef struct packed {
        logic fifoEmpty;
        logic fifoFull;
        logic intPending;
    } dmaStatus_t;

    // Register map, word addresses
    localparam cpuBusPkg::regAddr_t REG_WTC    = 5'd1;
    localparam cpuBusPkg::regAddr_t REG_CNTR   = 5'd2;
    localparam cpuBusPkg::regAddr_t REG_ACR    = 5'd3;
    localparam cpuBusPkg::regAddr_t REG_ST_DMA = 5'd4;   // Write starts the transfer
    localparam cpuBusPkg::regAddr_t REG_CINT   = 5'd6;   // Write clears the interrupt
    localparam cpuBusPkg::regAddr_t REG_ISTR   = 5'd7;

    typedef enum logic [2:0] {stIdle, stArbitrate, stScsiByte, stMemCycle, stDone} dmaState_e;

endpackage

//--- design/cpuBusPkg.sv
package cpuBusPkg;

    typedef logic [31:0] longWord_t;   // Data word on the CPU bus
    typedef logic [31:0] memAddr_t;    // Byte address of a memory cycle
    typedef logic [4:0]  regAddr_t;    // Register word address, ADDR[6:2]

    // Register access from the CPU
    typedef struct packed {
        logic      sel;
        logic      write;
        regAddr_t  addr;
        longWord_t wdata;
    } regAccess_t;

    // Memory cycle driven while we own the bus
    typedef struct packed {
        logic      as;      // Address strobe
        logic      write;
        memAddr_t  addr;
        longWord_t wdata;
    } memCycle_t;

endpackage
